//--- source/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// register file and data memory sizes
`define MIPS_NUM_REGS   32
`define MIPS_DMEM_WORDS 64   // word index taken from address bits above [1:0]

// opcode field instr[31:26]
`define OP_RTYPE 6'd0
`define OP_BEQ   6'd4
`define OP_ADDI  6'd8
`define OP_LW    6'd35
`define OP_SW    6'd43

// r-type funct field instr[5:0]
`define FN_ADD 6'd0
`define FN_MUL 6'd1
`define FN_SUB 6'd2

`endif

//--- source/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;     // data or byte address
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL
    } alu_op_t;

    typedef enum logic [2:0] {
        K_RTYPE,
        K_ADDI,
        K_LW,
        K_SW,
        K_BEQ,
        K_NOP     // anything not decoded
    } instr_kind_t;

    // decode -> execute
    typedef struct packed {
        instr_kind_t kind;
        alu_op_t     alu_op;
        reg_idx_t    dest;
        logic        write_en;
        word_t       op_a;       // rs, forwarded
        word_t       op_b;       // rt, forwarded
        word_t       imm;        // sign extended
        word_t       pc;
    } dec_pkt_t;

    // execute -> memory
    typedef struct packed {
        instr_kind_t kind;
        reg_idx_t    dest;
        logic        write_en;
        word_t       result;     // alu result, mem address or branch target
        word_t       store_data;
        logic        zero;
        word_t       pc;
    } exe_pkt_t;

    // one record per retired instruction
    typedef struct packed {
        instr_kind_t kind;
        reg_idx_t    dest;
        logic        write_en;
        word_t       value;
        logic        taken;
        word_t       pc;
    } result_t;

    // register write-back from memory stage
    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        word_t    data;
    } wb_t;

    // execute stage bypass, is_load marks a result that is only an address
    typedef struct packed {
        reg_idx_t dest;
        logic     write_en;
        word_t    result;
        logic     is_load;
    } fwd_t;

endpackage

`default_nettype wire

//--- source/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_consts.svh"

module decode_stage (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     in_valid,
    input  wire mips_pkg::instr_t   in_instr,
    input  wire                     hold,
    input  wire mips_pkg::fwd_t     fwd_exe,
    input  wire mips_pkg::wb_t      wb,
    output logic                    in_ready,
    output logic                    dec_valid,
    output mips_pkg::dec_pkt_t      dec_pkt
);

    import mips_pkg::*;

    word_t       regs [`MIPS_NUM_REGS];
    word_t       pc;                 // counts accepted instructions
    logic        active;             // low until reset is released
    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    instr_kind_t kind;
    alu_op_t     alu_op;
    reg_idx_t    dest;
    logic        write_en;
    logic        uses_rs;
    logic        uses_rt;
    word_t       rs_val;
    word_t       rt_val;
    word_t       imm_ext;
    logic        load_use;
    logic        accept;

    // r0 reads zero, then the younger bypass wins over write-back
    function automatic word_t fwd_sel(reg_idx_t idx, word_t rf_val, fwd_t fe, wb_t w);
        word_t v;
        if (idx == '0)
            v = '0;
        else if (fe.write_en && fe.dest == idx)
            v = fe.result;
        else if (w.en && w.idx == idx)
            v = w.data;
        else
            v = rf_val;
        return v;
    endfunction

    assign opcode  = in_instr[31:26];
    assign rs      = in_instr[25:21];
    assign rt      = in_instr[20:16];
    assign rd      = in_instr[15:11];
    assign funct   = in_instr[5:0];
    assign imm_ext = {{16{in_instr[15]}}, in_instr[15:0]};

    always_comb
    begin
        kind   = K_NOP;
        alu_op = ALU_ADD;
        case (opcode)
            `OP_RTYPE:
            begin
                kind = K_RTYPE;
                case (funct)
                    `FN_ADD: alu_op = ALU_ADD;
                    `FN_SUB: alu_op = ALU_SUB;
                    `FN_MUL: alu_op = ALU_MUL;
                    default: kind   = K_NOP;   // unknown funct retires as nop
                endcase
            end
            `OP_ADDI: kind = K_ADDI;
            `OP_LW:   kind = K_LW;
            `OP_SW:   kind = K_SW;
            `OP_BEQ:  kind = K_BEQ;
            default:  kind = K_NOP;
        endcase
    end

    always_comb
    begin
        case (kind)
            K_RTYPE:      dest = rd;
            K_ADDI, K_LW: dest = rt;
            default:      dest = '0;
        endcase
    end

    assign write_en = (dest != '0);   // writes to r0 are dropped here
    assign uses_rs  = (kind != K_NOP);
    assign uses_rt  = (kind == K_RTYPE) || (kind == K_SW) || (kind == K_BEQ);

    assign rs_val = fwd_sel(rs, regs[rs], fwd_exe, wb);
    assign rt_val = fwd_sel(rt, regs[rt], fwd_exe, wb);

    // lw in execute has only its address, so wait one cycle for the data
    assign load_use = fwd_exe.is_load && fwd_exe.write_en &&
                      ((uses_rs && rs == fwd_exe.dest) || (uses_rt && rt == fwd_exe.dest));

    assign in_ready = active && !hold && !load_use;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            active    <= 1'b0;
            pc        <= '0;
            dec_valid <= 1'b0;
        end
        else
        begin
            active <= 1'b1;
            if (!hold)
            begin
                dec_valid <= accept;   // no accept means a bubble
                if (accept)
                    pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!hold && accept)
        begin
            dec_pkt.kind     <= kind;
            dec_pkt.alu_op   <= alu_op;
            dec_pkt.dest     <= dest;
            dec_pkt.write_en <= write_en;
            dec_pkt.op_a     <= rs_val;
            dec_pkt.op_b     <= rt_val;
            dec_pkt.imm      <= imm_ext;
            dec_pkt.pc       <= pc;
        end
    end

    // register file, written on the edge the memory stage retires
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wb.en)
        begin
            regs[wb.idx] <= wb.data;
        end
    end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     hold,
    input  wire                     dec_valid,
    input  wire mips_pkg::dec_pkt_t dec_pkt,
    output logic                    exe_valid,
    output mips_pkg::exe_pkt_t      exe_pkt,
    output mips_pkg::fwd_t          fwd_exe
);

    import mips_pkg::*;

    alu_op_t     alu_ctl;
    word_t       src_b;
    logic [63:0] mul_full;
    word_t       alu_out;
    word_t       br_target;
    word_t       result;
    logic        zero;

    // only r-type picks its op from funct, the rest compute an add
    assign alu_ctl = (dec_pkt.kind == K_RTYPE) ? dec_pkt.alu_op : ALU_ADD;

    // second operand select
    always_comb
    begin
        case (dec_pkt.kind)
            K_ADDI, K_LW, K_SW: src_b = dec_pkt.imm;
            default:            src_b = dec_pkt.op_b;
        endcase
    end

    assign mul_full = dec_pkt.op_a * src_b;

    always_comb
    begin
        case (alu_ctl)
            ALU_SUB: alu_out = dec_pkt.op_a - src_b;
            ALU_MUL: alu_out = mul_full[31:0];   // low half only
            default: alu_out = dec_pkt.op_a + src_b;
        endcase
    end

    // beq target is pc + 4 + imm*4
    assign br_target = dec_pkt.pc + 32'd4 + {dec_pkt.imm[29:0], 2'b00};
    assign zero      = (dec_pkt.kind == K_BEQ) && (dec_pkt.op_a == dec_pkt.op_b);

    always_comb
    begin
        case (dec_pkt.kind)
            K_BEQ:   result = br_target;
            K_NOP:   result = '0;
            default: result = alu_out;
        endcase
    end

    // bypass to decode straight from this cycle's alu
    always_comb
    begin
        fwd_exe.dest     = dec_pkt.dest;
        fwd_exe.write_en = dec_valid && dec_pkt.write_en;
        fwd_exe.result   = result;
        fwd_exe.is_load  = (dec_pkt.kind == K_LW);
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            exe_valid <= 1'b0;
        else if (!hold)
            exe_valid <= dec_valid;
    end

    always_ff @(posedge clk)
    begin
        if (!hold)
        begin
            exe_pkt.kind       <= dec_pkt.kind;
            exe_pkt.dest       <= dec_pkt.dest;
            exe_pkt.write_en   <= dec_pkt.write_en;
            exe_pkt.result     <= result;
            exe_pkt.store_data <= dec_pkt.op_b;   // rt value for sw
            exe_pkt.zero       <= zero;
            exe_pkt.pc         <= dec_pkt.pc;
        end
    end

endmodule

`default_nettype wire

//--- source/memory_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_consts.svh"

module memory_stage (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     exe_valid,
    input  wire mips_pkg::exe_pkt_t exe_pkt,
    input  wire                     out_ready,
    output logic                    hold,
    output mips_pkg::wb_t           wb,
    output logic                    out_valid,
    output mips_pkg::result_t       out_result
);

    import mips_pkg::*;

    localparam int ADDR_W = $clog2(`MIPS_DMEM_WORDS);

    word_t             dmem [`MIPS_DMEM_WORDS];
    logic [ADDR_W-1:0] word_addr;
    word_t             load_data;
    word_t             ret_val;
    result_t           rec;

    // stalled output freezes the whole pipe
    assign hold = out_valid && !out_ready;

    assign word_addr = exe_pkt.result[ADDR_W+1:2];
    assign load_data = dmem[word_addr];
    assign ret_val   = (exe_pkt.kind == K_LW) ? load_data : exe_pkt.result;

    // write-back lands on the same edge that loads out_result
    always_comb
    begin
        wb.en   = exe_valid && exe_pkt.write_en && !hold;
        wb.idx  = exe_pkt.dest;
        wb.data = ret_val;
    end

    always_comb
    begin
        rec.kind     = exe_pkt.kind;
        rec.dest     = exe_pkt.dest;
        rec.write_en = exe_pkt.write_en;
        rec.value    = ret_val;        // sw reports its address here
        rec.taken    = exe_pkt.zero;
        rec.pc       = exe_pkt.pc;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `MIPS_DMEM_WORDS; i++)
                dmem[i] <= '0;
        end
        else if (!hold && exe_valid && exe_pkt.kind == K_SW)
        begin
            dmem[word_addr] <= exe_pkt.store_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (!hold)
            out_valid <= exe_valid;
    end

    always_ff @(posedge clk)
    begin
        if (!hold)
            out_result <= rec;
    end

endmodule

`default_nettype wire

//--- source/mips_ex_core.sv
`timescale 1ns/1ns
`default_nettype none

module mips_ex_core (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   in_valid,
    input  wire mips_pkg::instr_t in_instr,
    input  wire                   out_ready,
    output logic                  in_ready,
    output logic                  out_valid,
    output mips_pkg::result_t     out_result
);

    import mips_pkg::*;

    logic     hold;        // from output handshake
    logic     dec_valid;
    dec_pkt_t dec_pkt;
    logic     exe_valid;
    exe_pkt_t exe_pkt;
    fwd_t     fwd_exe;
    wb_t      wb;

    decode_stage decode_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .hold      (hold),
        .fwd_exe   (fwd_exe),
        .wb        (wb),
        .in_ready  (in_ready),
        .dec_valid (dec_valid),
        .dec_pkt   (dec_pkt)
    );

    execute_stage execute_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .hold      (hold),
        .dec_valid (dec_valid),
        .dec_pkt   (dec_pkt),
        .exe_valid (exe_valid),
        .exe_pkt   (exe_pkt),
        .fwd_exe   (fwd_exe)
    );

    memory_stage memory_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .exe_valid  (exe_valid),
        .exe_pkt    (exe_pkt),
        .out_ready  (out_ready),
        .hold       (hold),
        .wb         (wb),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

endmodule

`default_nettype wire

//--- bench/core_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_consts.svh"

module core_tb;

    import mips_pkg::*;

    localparam int NUM_INSTR      = 200;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 12;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     in_valid;
    instr_t   in_instr;
    logic     in_ready;
    logic     out_valid;
    result_t  out_result;
    logic     out_ready;

    instr_t      prog [$];
    result_t     exp_q [$];
    result_t     exp_rec;
    result_t     held;
    logic        stalled = 1'b0;
    int          next_idx = 0;
    int          received = 0;
    int          cycles = 0;
    int          rst_cycles = 0;

    // reference state
    word_t m_regs [`MIPS_NUM_REGS] = '{default: '0};
    word_t m_mem [`MIPS_DMEM_WORDS] = '{default: '0};
    word_t m_pc = '0;

    mips_ex_core mips_ex_core_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .out_ready  (out_ready),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    always #10 clk = ~clk;

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(string name, word_t got, word_t exp);
        abort_run($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_result(string name, result_t got, result_t exp);
        if (got.value !== exp.value)
            report_mismatch({name, ".value"}, got.value, exp.value);
        if (got.dest !== exp.dest)
            report_mismatch({name, ".dest"}, 32'(got.dest), 32'(exp.dest));
        if (got.kind !== exp.kind)
            report_mismatch({name, ".kind"}, 32'(got.kind), 32'(exp.kind));
        if (got.taken !== exp.taken)
            report_mismatch({name, ".taken"}, 32'(got.taken), 32'(exp.taken));
        if (got.write_en !== exp.write_en)
            report_mismatch({name, ".write_en"}, 32'(got.write_en), 32'(exp.write_en));
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp)
            report_mismatch(name, got, exp);
    endtask

    function automatic instr_t enc_r(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, logic [5:0] fn);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic instr_t enc_i(logic [5:0] op, reg_idx_t rs, reg_idx_t rt,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic reg_idx_t pick_reg();
        return reg_idx_t'($urandom % 8);   // few regs give many dependencies
    endfunction

    function automatic logic [5:0] pick_funct();
        int unsigned x;
        x = $urandom % 8;
        if (x == 7)
            return 6'd5;                   // undecoded funct
        return 6'(x % 3);
    endfunction

    // expected record for one accepted instruction
    function automatic result_t model_step(instr_t ins);
        result_t r;
        word_t   a;
        word_t   b;
        word_t   imm;
        word_t   addr;
        a    = m_regs[ins[25:21]];
        b    = m_regs[ins[20:16]];
        imm  = {{16{ins[15]}}, ins[15:0]};
        addr = a + imm;
        r      = '0;
        r.kind = K_NOP;
        r.pc   = m_pc;
        case (ins[31:26])
            `OP_RTYPE:
            begin
                r.kind = K_RTYPE;
                r.dest = ins[15:11];
                if (ins[5:0] == `FN_ADD)
                    r.value = a + b;
                else if (ins[5:0] == `FN_SUB)
                    r.value = a - b;
                else if (ins[5:0] == `FN_MUL)
                    r.value = a * b;       // low 32 bits
                else
                begin
                    r.kind = K_NOP;
                    r.dest = '0;
                end
            end
            `OP_ADDI:
            begin
                r.kind  = K_ADDI;
                r.dest  = ins[20:16];
                r.value = addr;
            end
            `OP_LW:
            begin
                r.kind  = K_LW;
                r.dest  = ins[20:16];
                r.value = m_mem[addr[7:2]];   // 64 words
            end
            `OP_SW:
            begin
                r.kind  = K_SW;
                r.value = addr;
                m_mem[addr[7:2]] = b;
            end
            `OP_BEQ:
            begin
                r.kind  = K_BEQ;
                r.value = m_pc + 32'd4 + (imm << 2);
                r.taken = (a == b);
            end
            default: r.kind = K_NOP;
        endcase
        r.write_en = (r.dest != '0);
        if (r.write_en)
            m_regs[r.dest] = r.value;
        m_pc = m_pc + 32'd4;
        return r;
    endfunction

    task automatic build_program();
        reg_idx_t    a;
        reg_idx_t    b;
        logic [15:0] off;
        int unsigned cat;
        // every register pair compared right after reset and all taken
        for (int i = 0; i < 16; i++)
            prog.push_back(enc_i(`OP_BEQ, reg_idx_t'(2 * i), reg_idx_t'(2 * i + 1), 16'(i)));
        while (prog.size() < NUM_INSTR)
        begin
            cat = $urandom % 10;
            a   = pick_reg();
            b   = pick_reg();
            off = 16'(4 * ($urandom % 16));
            case (cat)
                0, 1: prog.push_back(enc_r(a, b, pick_reg(), pick_funct()));
                2:    prog.push_back(enc_i(`OP_ADDI, a, b, 16'($urandom)));
                3:
                begin
                    // chain through both bypass paths
                    prog.push_back(enc_i(`OP_ADDI, a, b, 16'($urandom % 300)));
                    prog.push_back(enc_r(b, b, a, pick_funct()));
                    prog.push_back(enc_r(a, b, b, `FN_SUB));
                end
                4:
                begin
                    prog.push_back(enc_i(`OP_SW, 5'd0, a, off));
                    prog.push_back(enc_i(`OP_LW, 5'd0, b, off));
                end
                5:
                begin
                    prog.push_back(enc_i(`OP_LW, 5'd0, a, off));
                    prog.push_back(enc_r(a, b, b, `FN_ADD));   // load-use
                end
                6: prog.push_back(enc_i(`OP_BEQ, a, ($urandom % 2) ? a : b, 16'($urandom)));
                7: prog.push_back(enc_i(`OP_SW, 5'd0, a, off));
                8: prog.push_back({6'h3f, 26'($urandom)});
                default:
                begin
                    prog.push_back(enc_i(`OP_ADDI, a, 5'd0, 16'($urandom)));
                    prog.push_back(enc_r(5'd0, a, b, `FN_ADD));
                end
            endcase
        end
        while (prog.size() > NUM_INSTR)
            void'(prog.pop_back());
    endtask

    // input stream and output back-pressure
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (in_valid && in_ready)
                exp_q.push_back(model_step(in_instr));
            if (!in_valid || in_ready)
            begin
                if (next_idx < NUM_INSTR && ($urandom % 10) >= 3)
                begin
                    in_valid <= 1'b1;
                    in_instr <= prog[next_idx];
                    next_idx <= next_idx + 1;
                end
                else
                    in_valid <= 1'b0;
            end
            out_ready <= ($urandom % 10) >= 3;
        end
    end

    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (stalled)
            begin
                if (!out_valid)
                    abort_run("out_valid dropped while the output was stalled");
                check_result("out_result(stalled)", out_result, held);
                check_word("out_result.pc(stalled)", out_result.pc, held.pc);
            end
            if (out_valid && out_ready)
            begin
                if (exp_q.size() == 0)
                    abort_run("output record appeared with no instruction pending");
                exp_rec = exp_q.pop_front();
                check_result("out_result", out_result, exp_rec);
                check_word("out_result.pc", out_result.pc, exp_rec.pc);
                received <= received + 1;
            end
            stalled <= out_valid && !out_ready;
            held    <= out_result;
        end
    end

    // first edge only loads the reset values
    always @(posedge clk)
    begin
        if (!rst_n && rst_cycles > 0)
        begin
            if (in_ready !== 1'b0)
                abort_run("in_ready was not low during reset");
            if (out_valid !== 1'b0)
                abort_run("out_valid was not low during reset");
        end
        if (!rst_n)
            rst_cycles <= rst_cycles + 1;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            abort_run($sformatf("timeout after %0d cycles with %0d of %0d records seen",
                                cycles, received, NUM_INSTR));
    end

    initial
    begin
        void'($urandom(32'hf549));
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        out_ready = 1'b0;
        build_program();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        wait (received == NUM_INSTR);
        repeat (4) @(posedge clk);   // let any extra record show up
        if (exp_q.size() == 0 && !out_valid && next_idx == NUM_INSTR)
        begin
            $display("TEST PASS");
            $finish;
        end
        else
            abort_run("records or instructions left over at the end of the run");
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+source
source/mips_pkg.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/mips_ex_core.sv
bench/core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module core_tb -o core_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/core_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0
